// File: sim.f
design/apu_pkg.sv
design/apu_op_decode.sv
design/apu_disp.sv
design/apu_exec.sv
design/apu_regfile.sv
design/apu_top.sv
verif/apu_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --assert -f sim.f --top-module apu_tb -o apu_sim &&
./obj_dir/apu_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation result: pass" || {
	echo "Simulation result: fail"
	exit 1
}

// File: verif/apu_tb.sv
`timescale 1ns/100ps

module apu_tb;
	import apu_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic                  clk_i;
	logic                  rst_ni;
	logic [INSTR_W-1:0]    instr_i;
	logic                  instr_valid_i;
	logic                  instr_ready_o;
	logic [REG_ADDR_W-1:0] dbg_raddr_i;
	logic [DATA_W-1:0]     dbg_rdata_o;
	logic                  busy_o;

	logic [DATA_W-1:0] ref_regs [NUM_REGS];
	logic              check_en;
	int                err_count;
	int                tests_passed;
	int                tests_failed;

	apu_top DUT (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.instr_ready_o (instr_ready_o),
		.dbg_raddr_i   (dbg_raddr_i),
		.dbg_rdata_o   (dbg_rdata_o),
		.busy_o        (busy_o)
	);

	always #10 clk_i = ~clk_i;

	// Architectural result of one instruction, all arithmetic modulo 2^32.
	function automatic logic [DATA_W-1:0] ref_result(input apu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input logic [DATA_W-1:0] c, input logic [DATA_W-1:0] imm);
		logic [DATA_W-1:0] res;
		case (op)
			OP_LDI: res = imm;
			OP_SUB: res = a - b;
			OP_MAC: res = a * b + c;
			default: res = (b == 0) ? '1 : a / b;
		endcase
		return res;
	endfunction

	function automatic logic [INSTR_W-1:0] encode_op(input apu_op_e op, input int rd,
		input int rs1, input int rs2, input int rs3);
		return {op, 4'b0000, REG_ADDR_W'(rd), 2'b00, REG_ADDR_W'(rs1),
			REG_ADDR_W'(rs2), REG_ADDR_W'(rs3)};
	endfunction

	function automatic logic [INSTR_W-1:0] encode_ldi(input int rd, input logic [17:0] imm);
		return {OP_LDI, 4'b0000, REG_ADDR_W'(rd), 2'b00, imm};
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$finish;
	endtask

	// Holds the instruction until the DUT takes it, then updates the model.
	task automatic issue_instr(input logic [INSTR_W-1:0] word);
		int waited;
		apu_op_e op;
		waited = 0;
		op = apu_op_e'(word[31:30]);
		@(negedge clk_i);
		instr_i = word;
		instr_valid_i = 1'b1;
		#1;
		while (!instr_ready_o && waited < WAIT_LIMIT) begin
			@(negedge clk_i);
			#1;
			waited++;
		end
		if (!instr_ready_o) begin
			$display("Instruction %h was not accepted within %0d cycles", word, WAIT_LIMIT);
			abort_run();
		end else begin
			@(posedge clk_i);
			ref_regs[word[25:20]] = ref_result(op, ref_regs[word[17:12]],
				ref_regs[word[11:6]], ref_regs[word[5:0]], {14'd0, word[17:0]});
		end
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		@(negedge clk_i);
		instr_valid_i = 1'b0;
		while (busy_o && waited < WAIT_LIMIT) begin
			@(negedge clk_i);
			waited++;
		end
		if (busy_o) begin
			$display("Results were still in flight after %0d cycles", WAIT_LIMIT);
			abort_run();
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i < NUM_REGS; i++) begin
			@(negedge clk_i);
			check_en = 1'b1;
			dbg_raddr_i = REG_ADDR_W'(i);
		end
		@(negedge clk_i);
		check_en = 1'b0;
	endtask

	task automatic close_test(input int num, input string name, input int errs_before);
		if (err_count == errs_before) begin
			tests_passed++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d mismatches", num, name, err_count - errs_before);
		end
	endtask

	// Nothing is written while checking, so the debug port is stable here.
	always @(posedge clk_i) begin
		if (check_en) begin
			assert (dbg_rdata_o === ref_regs[dbg_raddr_i])
			else begin
				$display("** Error: dbg_rdata_o for register %0d expected %h, got %h",
					dbg_raddr_i, ref_regs[dbg_raddr_i], dbg_rdata_o);
				err_count++;
			end
		end
	end

	initial begin
		int errs;
		int prev;
		logic [1:0] op_bits;
		void'($urandom(6606));
		clk_i = 1'b0;
		rst_ni = 1'b0;
		instr_i = '0;
		instr_valid_i = 1'b0;
		dbg_raddr_i = '0;
		check_en = 1'b0;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < NUM_REGS; i++)
			ref_regs[i] = '0;
		repeat (10) @(negedge clk_i);
		rst_ni = 1'b1;

		errs = err_count;
		// An idle unit is ready and has nothing outstanding.
		assert (busy_o === 1'b0)
		else begin
			$display("** Error: busy_o after reset expected %h, got %h", 1'b0, busy_o);
			err_count++;
		end
		assert (instr_ready_o === 1'b1)
		else begin
			$display("** Error: instr_ready_o after reset expected %h, got %h",
				1'b1, instr_ready_o);
			err_count++;
		end
		check_regs();
		issue_instr(encode_ldi(1, 18'h3ffff));
		issue_instr(encode_ldi(2, 18'd12345));
		issue_instr(encode_ldi(3, 18'd7));
		issue_instr(encode_ldi(63, 18'h2a5a5));
		drain_results();
		check_regs();
		close_test(1, "reset and LDI", errs);

		// Each SUB reads the result of the one before it.
		errs = err_count;
		issue_instr(encode_ldi(4, 18'd100000));
		issue_instr(encode_ldi(5, 18'd3));
		prev = 4;
		for (int k = 0; k < 10; k++) begin
			issue_instr(encode_op(OP_SUB, 10 + k, prev, (k % 2) ? 5 : 3, 0));
			prev = 10 + k;
		end
		issue_instr(encode_op(OP_SUB, 8, 5, 1, 0));
		issue_instr(encode_op(OP_SUB, 8, 8, 19, 0));
		drain_results();
		check_regs();
		close_test(2, "SUB chain", errs);

		errs = err_count;
		issue_instr(encode_ldi(20, 18'h1234));
		issue_instr(encode_ldi(21, 18'h5678));
		issue_instr(encode_ldi(22, 18'd9));
		issue_instr(encode_op(OP_MAC, 23, 20, 21, 22));
		issue_instr(encode_op(OP_MAC, 24, 21, 21, 20));
		issue_instr(encode_op(OP_MAC, 25, 1, 1, 2));
		issue_instr(encode_op(OP_MAC, 26, 20, 22, 3));
		issue_instr(encode_op(OP_MAC, 26, 26, 22, 21));
		issue_instr(encode_op(OP_MAC, 27, 26, 25, 24));
		drain_results();
		check_regs();
		close_test(3, "MAC pipeline", errs);

		errs = err_count;
		issue_instr(encode_ldi(30, 18'd250000));
		issue_instr(encode_ldi(31, 18'd7));
		issue_instr(encode_ldi(32, 18'd0));
		issue_instr(encode_op(OP_DIV, 33, 30, 31, 0));
		issue_instr(encode_op(OP_SUB, 34, 33, 31, 0));
		issue_instr(encode_op(OP_SUB, 35, 30, 31, 0));
		issue_instr(encode_op(OP_MAC, 36, 33, 31, 35));
		issue_instr(encode_op(OP_DIV, 37, 30, 32, 0));
		issue_instr(encode_op(OP_MAC, 38, 30, 31, 37));
		issue_instr(encode_op(OP_DIV, 39, 23, 31, 0));
		issue_instr(encode_op(OP_DIV, 40, 39, 39, 0));
		issue_instr(encode_op(OP_SUB, 41, 37, 33, 0));
		drain_results();
		check_regs();
		close_test(4, "DIV and mixed", errs);

		// Sources and destinations come from a small window to provoke hazards.
		errs = err_count;
		for (int n = 0; n < 300; n++) begin
			op_bits = 2'($urandom_range(3, 0));
			if (apu_op_e'(op_bits) == OP_LDI)
				issue_instr(encode_ldi($urandom_range(15, 0), 18'($urandom)));
			else
				issue_instr(encode_op(apu_op_e'(op_bits), $urandom_range(15, 0),
					$urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0)));
		end
		drain_results();
		check_regs();
		close_test(5, "random program", errs);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: design/apu_top.sv
`timescale 1ns/100ps

module apu_top (
	input  logic                              clk_i,
	input  logic                              rst_ni,
	input  logic [apu_pkg::INSTR_W-1:0]       instr_i,
	input  logic                              instr_valid_i,
	output logic                              instr_ready_o,
	input  logic [apu_pkg::REG_ADDR_W-1:0]    dbg_raddr_i,
	output logic [apu_pkg::DATA_W-1:0]        dbg_rdata_o,
	output logic                              busy_o
);
	import apu_pkg::*;

	apu_op_e                                 op;
	logic [REG_ADDR_W-1:0]                   rd;
	logic [NUM_RD_PORTS-1:0][REG_ADDR_W-1:0] rs;
	logic [NUM_RD_PORTS-1:0]                 rs_valid;
	logic [1:0]                              lat;
	logic [DATA_W-1:0]                       imm;
	logic                                    disp_enable;
	logic                                    read_dep, write_dep, stall;
	logic                                    apu_req, apu_gnt, apu_rvalid;
	logic [DATA_W-1:0]                       apu_result;
	logic [REG_ADDR_W-1:0]                   wb_addr;
	logic [NUM_RD_PORTS-1:0][DATA_W-1:0]     operand;

	apu_op_decode u_decode (
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.read_dep_i    (read_dep),
		.write_dep_i   (write_dep),
		.stall_i       (stall),
		.op_o          (op),
		.rd_o          (rd),
		.rs_o          (rs),
		.rs_valid_o    (rs_valid),
		.lat_o         (lat),
		.imm_o         (imm),
		.enable_o      (disp_enable),
		.instr_ready_o (instr_ready_o)
	);

	apu_disp u_disp (
		.clk_i              (clk_i),
		.rst_ni             (rst_ni),
		.enable_i           (disp_enable),
		.lat_i              (lat),
		.waddr_i            (rd),
		.read_regs_i        (rs),
		.read_regs_valid_i  (rs_valid),
		.write_regs_i       (rd),
		.write_regs_valid_i ({NUM_WR_PORTS{1'b1}}),
		.gnt_i              (apu_gnt),
		.rvalid_i           (apu_rvalid),
		.req_o              (apu_req),
		.waddr_o            (wb_addr),
		.read_dep_o         (read_dep),
		.write_dep_o        (write_dep),
		.stall_o            (stall),
		.active_o           (busy_o)
	);

	apu_exec u_exec (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.req_i    (apu_req),
		.op_i     (op),
		.opa_i    (operand[0]),
		.opb_i    (operand[1]),
		.opc_i    (operand[2]),
		.imm_i    (imm),
		.gnt_o    (apu_gnt),
		.rvalid_o (apu_rvalid),
		.result_o (apu_result)
	);

	apu_regfile u_regfile (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.we_i        (apu_rvalid),
		.waddr_i     (wb_addr),
		.wdata_i     (apu_result),
		.raddr_i     (rs),
		.dbg_raddr_i (dbg_raddr_i),
		.rdata_o     (operand),
		.dbg_rdata_o (dbg_rdata_o)
	);

endmodule

// File: design/apu_regfile.sv
`timescale 1ns/100ps

module apu_regfile (
	input  logic                                                  clk_i,
	input  logic                                                  rst_ni,
	input  logic                                                  we_i,
	input  logic [apu_pkg::REG_ADDR_W-1:0]                        waddr_i,
	input  logic [apu_pkg::DATA_W-1:0]                            wdata_i,
	input  logic [apu_pkg::NUM_RD_PORTS-1:0][apu_pkg::REG_ADDR_W-1:0] raddr_i,
	input  logic [apu_pkg::REG_ADDR_W-1:0]                        dbg_raddr_i,
	output logic [apu_pkg::NUM_RD_PORTS-1:0][apu_pkg::DATA_W-1:0]     rdata_o,
	output logic [apu_pkg::DATA_W-1:0]                            dbg_rdata_o
);
	import apu_pkg::*;

	logic [DATA_W-1:0] mem [NUM_REGS];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < NUM_REGS; i++)
				mem[i] <= '0;
		end else if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// A request reads the values from before this cycle's write. The
	// dispatcher holds it back while any of its sources is still outstanding.
	always_comb begin
		for (int i = 0; i < NUM_RD_PORTS; i++)
			rdata_o[i] = mem[raddr_i[i]];
	end

	assign dbg_rdata_o = mem[dbg_raddr_i];

endmodule

// File: design/apu_exec.sv
`timescale 1ns/100ps

module apu_exec (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        req_i,
	input  apu_pkg::apu_op_e            op_i,
	input  logic [apu_pkg::DATA_W-1:0]  opa_i,
	input  logic [apu_pkg::DATA_W-1:0]  opb_i,
	input  logic [apu_pkg::DATA_W-1:0]  opc_i,
	input  logic [apu_pkg::DATA_W-1:0]  imm_i,
	output logic                        gnt_o,
	output logic                        rvalid_o,
	output logic [apu_pkg::DATA_W-1:0]  result_o
);
	import apu_pkg::*;

	logic                 single_v;
	logic [DATA_W-1:0]    single_res;
	logic                 mac_start, mac_v1, mac_v2;
	logic [DATA_W-1:0]    prod_q, addend_q, sum_q;
	logic                 div_start, div_busy, div_done, div_step;
	logic [DIV_CNT_W-1:0] div_cnt;
	logic [DATA_W-1:0]    div_rem, div_quo, div_dvs;
	logic [DATA_W:0]      rem_sh;
	logic [DATA_W+1:0]    diff;

	assign gnt_o = (op_i == OP_DIV) ? ~div_busy : 1'b1;

	assign single_v = req_i & gnt_o & (op_i == OP_LDI || op_i == OP_SUB);
	assign single_res = (op_i == OP_LDI) ? imm_i : opa_i - opb_i;

	assign mac_start = req_i & gnt_o & (op_i == OP_MAC);
	assign div_start = req_i & gnt_o & (op_i == OP_DIV);

	// Restoring division, one quotient bit per cycle. A zero divisor
	// always subtracts, so the quotient comes out all ones.
	assign div_step = div_busy & (div_cnt != '0);
	assign div_done = div_busy & (div_cnt == '0);
	assign rem_sh = {div_rem, div_quo[DATA_W-1]};
	assign diff = {1'b0, rem_sh} - {2'b00, div_dvs};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mac_v1 <= 1'b0;
			mac_v2 <= 1'b0;
			div_busy <= 1'b0;
			div_cnt <= '0;
		end else begin
			mac_v1 <= mac_start;
			mac_v2 <= mac_v1;
			if (div_start) begin
				div_busy <= 1'b1;
				div_cnt <= DIV_CNT_W'(DIV_CYCLES);
			end else if (div_step) begin
				div_cnt <= div_cnt - 1'b1;
			end else if (div_done) begin
				div_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		prod_q <= opa_i * opb_i;
		addend_q <= opc_i;
		sum_q <= prod_q + addend_q;
		if (div_start) begin
			div_rem <= '0;
			div_quo <= opa_i;
			div_dvs <= opb_i;
		end else if (div_step) begin
			div_rem <= diff[DATA_W+1] ? rem_sh[DATA_W-1:0] : diff[DATA_W-1:0];
			div_quo <= {div_quo[DATA_W-2:0], ~diff[DATA_W+1]};
		end
	end

	assign rvalid_o = single_v | mac_v2 | div_done;

	always_comb begin
		if (div_done)
			result_o = div_quo;
		else if (mac_v2)
			result_o = sum_q;
		else
			result_o = single_res;
	end

	// The dispatcher's stall rules keep the three paths from colliding.
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		$onehot0({single_v, mac_v2, div_done}));

endmodule

// File: design/apu_disp.sv
`timescale 1ns/100ps

module apu_disp (
	input  logic                                                  clk_i,
	input  logic                                                  rst_ni,
	input  logic                                                  enable_i,
	input  logic [1:0]                                            lat_i,
	input  logic [apu_pkg::REG_ADDR_W-1:0]                        waddr_i,
	input  logic [apu_pkg::NUM_RD_PORTS-1:0][apu_pkg::REG_ADDR_W-1:0] read_regs_i,
	input  logic [apu_pkg::NUM_RD_PORTS-1:0]                      read_regs_valid_i,
	input  logic [apu_pkg::NUM_WR_PORTS-1:0][apu_pkg::REG_ADDR_W-1:0] write_regs_i,
	input  logic [apu_pkg::NUM_WR_PORTS-1:0]                      write_regs_valid_i,
	input  logic                                                  gnt_i,
	input  logic                                                  rvalid_i,
	output logic                                                  req_o,
	output logic [apu_pkg::REG_ADDR_W-1:0]                        waddr_o,
	output logic                                                  read_dep_o,
	output logic                                                  write_dep_o,
	output logic                                                  stall_o,
	output logic                                                  active_o
);
	import apu_pkg::*;

	logic [REG_ADDR_W-1:0] addr_inflight, addr_inflight_d;
	logic [REG_ADDR_W-1:0] addr_waiting, addr_waiting_d;
	logic                  valid_inflight, valid_inflight_d;
	logic                  valid_waiting, valid_waiting_d;
	logic                  valid_req;
	logic                  req_accepted;
	logic                  returned_req;
	logic                  returned_inflight;
	logic                  returned_waiting;
	logic                  active;
	logic [1:0]            last_lat;
	logic                  read_dep_inflight, read_dep_waiting;
	logic                  write_dep_inflight, write_dep_waiting;
	logic                  stall_full, stall_type, stall_nack;

	assign valid_req = enable_i & ~(stall_full | stall_type);
	assign req_accepted = valid_req & gnt_i;

	// A return is owned by the oldest outstanding entry. A request returns
	// in its own cycle only when nothing else is outstanding.
	assign returned_req = valid_req & rvalid_i & ~valid_inflight & ~valid_waiting;
	assign returned_inflight = valid_inflight & rvalid_i & ~valid_waiting;
	assign returned_waiting = valid_waiting & rvalid_i;

	always_comb begin
		valid_inflight_d = valid_inflight;
		valid_waiting_d = valid_waiting;
		addr_inflight_d = addr_inflight;
		addr_waiting_d = addr_waiting;
		if (req_accepted && !returned_req) begin
			valid_inflight_d = 1'b1;
			addr_inflight_d = waddr_i;
			if ((valid_inflight && !returned_inflight) || returned_waiting) begin
				valid_waiting_d = 1'b1;
				addr_waiting_d = addr_inflight;
			end
		end else if (returned_inflight) begin
			valid_inflight_d = 1'b0;
			valid_waiting_d = 1'b0;
			addr_inflight_d = '0;
			addr_waiting_d = '0;
		end else if (returned_waiting) begin
			valid_waiting_d = 1'b0;
			addr_waiting_d = '0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_inflight <= 1'b0;
			valid_waiting <= 1'b0;
			addr_inflight <= '0;
			addr_waiting <= '0;
			last_lat <= '0;
		end else begin
			valid_inflight <= valid_inflight_d;
			valid_waiting <= valid_waiting_d;
			addr_inflight <= addr_inflight_d;
			addr_waiting <= addr_waiting_d;
			if (valid_req) begin
				last_lat <= lat_i;
			end
		end
	end

	assign active = valid_inflight | valid_waiting;

	// Sources and destination of the new request against outstanding entries.
	always_comb begin
		read_dep_inflight = 1'b0;
		read_dep_waiting = 1'b0;
		write_dep_inflight = 1'b0;
		write_dep_waiting = 1'b0;
		for (int i = 0; i < NUM_RD_PORTS; i++) begin
			if (read_regs_valid_i[i] && read_regs_i[i] == addr_inflight)
				read_dep_inflight = valid_inflight;
			if (read_regs_valid_i[i] && read_regs_i[i] == addr_waiting)
				read_dep_waiting = valid_waiting;
		end
		for (int i = 0; i < NUM_WR_PORTS; i++) begin
			if (write_regs_valid_i[i] && write_regs_i[i] == addr_inflight)
				write_dep_inflight = valid_inflight;
			if (write_regs_valid_i[i] && write_regs_i[i] == addr_waiting)
				write_dep_waiting = valid_waiting;
		end
	end

	assign read_dep_o = read_dep_inflight | read_dep_waiting;
	assign write_dep_o = write_dep_inflight | write_dep_waiting;

	// Pipelined ops may overlap each other but never a multicycle one.
	assign stall_full = valid_inflight & valid_waiting;
	assign stall_type = enable_i & active &
		((lat_i == LAT_SINGLE) || (lat_i == LAT_MULTI) ||
		 (lat_i == LAT_PIPE && last_lat == LAT_MULTI));
	assign stall_nack = valid_req & ~gnt_i;
	assign stall_o = stall_full | stall_type | stall_nack;

	assign req_o = valid_req;
	assign active_o = active;

	always_comb begin
		waddr_o = '0;
		if (returned_req)
			waddr_o = waddr_i;
		if (returned_inflight)
			waddr_o = addr_inflight;
		if (returned_waiting)
			waddr_o = addr_waiting;
	end

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		rvalid_i |-> (req_o || active));

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		valid_waiting |-> valid_inflight);

endmodule

// File: design/apu_op_decode.sv
`timescale 1ns/100ps

module apu_op_decode (
	input  logic [apu_pkg::INSTR_W-1:0]                           instr_i,
	input  logic                                                  instr_valid_i,
	input  logic                                                  read_dep_i,
	input  logic                                                  write_dep_i,
	input  logic                                                  stall_i,
	output apu_pkg::apu_op_e                                      op_o,
	output logic [apu_pkg::REG_ADDR_W-1:0]                        rd_o,
	output logic [apu_pkg::NUM_RD_PORTS-1:0][apu_pkg::REG_ADDR_W-1:0] rs_o,
	output logic [apu_pkg::NUM_RD_PORTS-1:0]                      rs_valid_o,
	output logic [1:0]                                            lat_o,
	output logic [apu_pkg::DATA_W-1:0]                            imm_o,
	output logic                                                  enable_o,
	output logic                                                  instr_ready_o
);
	import apu_pkg::*;

	logic hazard;

	assign op_o = apu_op_e'(instr_i[OP_LSB +: 2]);
	assign rd_o = instr_i[RD_LSB +: REG_ADDR_W];
	assign rs_o[0] = instr_i[RS1_LSB +: REG_ADDR_W];
	assign rs_o[1] = instr_i[RS2_LSB +: REG_ADDR_W];
	assign rs_o[2] = instr_i[RS3_LSB +: REG_ADDR_W];
	assign imm_o = {{(DATA_W - IMM_W){1'b0}}, instr_i[IMM_W-1:0]};

	// Latency class and the sources each operation actually reads.
	always_comb begin
		unique case (op_o)
			OP_LDI: begin
				lat_o = LAT_SINGLE;
				rs_valid_o = 3'b000;
			end
			OP_SUB: begin
				lat_o = LAT_SINGLE;
				rs_valid_o = 3'b011;
			end
			OP_MAC: begin
				lat_o = LAT_PIPE;
				rs_valid_o = 3'b111;
			end
			default: begin
				lat_o = LAT_MULTI;
				rs_valid_o = 3'b011;
			end
		endcase
	end

	// The dispatcher only ever sees hazard-free requests.
	assign hazard = read_dep_i | write_dep_i;
	assign enable_o = instr_valid_i & ~hazard;
	assign instr_ready_o = ~stall_i & ~hazard;

endmodule

// File: design/apu_pkg.sv
package apu_pkg;

	localparam int INSTR_W = 32;
	localparam int REG_ADDR_W = 6;
	localparam int NUM_REGS = 1 << REG_ADDR_W;
	localparam int DATA_W = 32;
	localparam int NUM_RD_PORTS = 3;
	localparam int NUM_WR_PORTS = 1;

	// Latency classes. Code 0 is not used.
	localparam logic [1:0] LAT_SINGLE = 2'd1;
	localparam logic [1:0] LAT_PIPE = 2'd2;
	localparam logic [1:0] LAT_MULTI = 2'd3;

	// Instruction fields. The LDI immediate sits in the low bits and is zero-extended.
	localparam int OP_LSB = 30;
	localparam int RD_LSB = 20;
	localparam int RS1_LSB = 12;
	localparam int RS2_LSB = 6;
	localparam int RS3_LSB = 0;
	localparam int IMM_W = 18;

	localparam int DIV_CYCLES = 32;
	localparam int DIV_CNT_W = $clog2(DIV_CYCLES + 1);

	// LDI:  rd = imm
	// SUB:  rd = rs1 - rs2
	// MAC:  rd = rs1 * rs2 + rs3
	// DIV:  rd = rs1 / rs2, all ones when rs2 is zero
	typedef enum logic [1:0] {
		OP_LDI = 2'd0,
		OP_SUB = 2'd1,
		OP_MAC = 2'd2,
		OP_DIV = 2'd3
	} apu_op_e;

endpackage
